//--- bench/vpid_receiver_sva.sv
`timescale 1ns/1ps

module vpid_receiver_sva (
   input logic                   anc_detected,
   input logic                   calc_cs,
   input vpid_pkg::anc_word_t    anc_in,
   input vpid_pkg::vpid_bytes_t  vpid,
   input vpid_pkg::vpid_status_t status
);

   // A packet ends either good or with a checksum error, never both
   status_exclusive: assert property (@(posedge anc_detected) disable iff (calc_cs)
      !(status.vpid_valid && status.checksum_error))
      else $error("vpid_valid and checksum_error are high together");

   // Second clock of reset onward, the outputs sit at zero
   reset_clears: assert property (@(posedge anc_detected)
      calc_cs && $past(calc_cs) |-> ({vpid, status} == '0))
      else $error("Outputs are not zero during reset");

   // Only an accepted CS word can move the outputs
   change_after_word: assert property (@(posedge anc_detected) disable iff (calc_cs)
      !$stable({vpid, status}) |-> $past(anc_in.valid))
      else $error("Outputs changed without a valid word in the previous cycle");

endmodule

bind vpid_receiver vpid_receiver_sva u_sva (
   .anc_detected (anc_detected),
   .calc_cs      (calc_cs),
   .anc_in       (anc_in),
   .vpid         (vpid),
   .status       (status)
);

//--- bench/vpid_receiver_tb.sv
`timescale 1ns/1ps
`include "vpid_defines.svh"

module vpid_receiver_tb;

   localparam int TIMEOUT_CYCLES = 20;
   localparam vpid_pkg::vpid_status_t STATUS_GOOD = '{vpid_valid: 1'b1, checksum_error: 1'b0};
   localparam vpid_pkg::vpid_status_t STATUS_BAD  = '{vpid_valid: 1'b0, checksum_error: 1'b1};

   logic                   anc_detected;
   logic                   calc_cs;
   vpid_pkg::anc_word_t    anc_in;
   vpid_pkg::vpid_bytes_t  vpid;
   vpid_pkg::vpid_status_t status;

   int                     error_count;
   int                     timeout_count;
   logic [31:0]            lcg_state;
   logic [`ANC_WORD_W-1:0] packet[$];
   vpid_pkg::vpid_bytes_t  good_bytes;

   vpid_receiver DUT (
      .anc_detected (anc_detected),
      .calc_cs      (calc_cs),
      .anc_in       (anc_in),
      .vpid         (vpid),
      .status       (status)
   );

   initial begin
      anc_detected = 1'b0;
      forever #4 anc_detected = ~anc_detected;
   end

   function automatic logic [7:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[23:16];
   endfunction

   function automatic vpid_pkg::vpid_bytes_t random_bytes();
      return {next_random(), next_random(), next_random(), next_random()};
   endfunction

   // Even parity of the byte goes to bit 8 and its inverse to bit 9
   function automatic logic [`ANC_WORD_W-1:0] with_parity(input logic [7:0] b);
      logic p;
      p = ^b;
      return {~p, p, b};
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
      if (actual !== expected) begin
         error_count++;
         $display("ERROR at %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
      end
   endtask

   task automatic drive_word(input logic valid, input logic [`ANC_WORD_W-1:0] data);
      @(posedge anc_detected);
      #1;
      anc_in.valid = valid;
      anc_in.data  = data;
   endtask

   // ------------------------------
   // Packet building and sending
   // ------------------------------
   // A bad_udw index of -1 means every UDW keeps correct parity
   task automatic build_packet(input logic [`ANC_WORD_W-1:0] did,
                               input vpid_pkg::vpid_bytes_t bytes,
                               input logic corrupt_cs, input int bad_udw);
      logic [`ANC_CS_W-1:0]   sum;
      logic [`ANC_WORD_W-1:0] w;
      packet.delete();
      packet.push_back(`ADF_WORD0);
      packet.push_back(`ADF_WORD1);
      packet.push_back(`ADF_WORD1);
      packet.push_back(did);
      packet.push_back(`VPID_SDID_WORD);
      packet.push_back(`VPID_DC_WORD);
      for (int i = 0; i < `VPID_UDW_COUNT; i++) begin
         w = with_parity(bytes[31 - 8 * i -: 8]);
         if (i == bad_udw) begin
            w[8] = ~w[8];
         end
         packet.push_back(w);
      end
      // Sum of bits 8..0 from DID through the last UDW, carries dropped
      sum = '0;
      for (int i = 3; i < packet.size(); i++) begin
         sum = sum + packet[i][`ANC_CS_W-1:0];
      end
      w = {~sum[`ANC_CS_W-1], sum};
      if (corrupt_cs) begin
         w = w ^ 10'h001;
      end
      packet.push_back(w);
   endtask

   // With gaps on, invalid cycles are always placed inside the flag and the UDWs
   task automatic send_packet(input logic use_gaps);
      logic [7:0] r;
      int         gap;
      foreach (packet[i]) begin
         r = next_random();
         if (use_gaps && (r < 8'd80 || i == 2 || i == 7)) begin
            gap = 1 + int'(r[1:0]);
            repeat (gap) drive_word(1'b0, {2'b11, next_random()});
         end
         drive_word(1'b1, packet[i]);
      end
   endtask

   // Waits for the status to take its new value, which is due one cycle after the CS word
   task automatic expect_outputs(input vpid_pkg::vpid_bytes_t exp_vpid,
                                 input vpid_pkg::vpid_status_t exp_status, input string msg);
      int cycles;
      cycles = 0;
      while (status !== exp_status && cycles < TIMEOUT_CYCLES) begin
         drive_word(1'b0, '0);
         cycles++;
      end
      if (status !== exp_status) begin
         timeout_count++;
         $display("Timed out in %s waiting for the status to update", msg);
      end else begin
         check_value(cycles, 1, {msg, " latency"});
         check_value(vpid, exp_vpid, {msg, " vpid"});
      end
   endtask

   task automatic expect_unchanged(input vpid_pkg::vpid_bytes_t exp_vpid,
                                   input vpid_pkg::vpid_status_t exp_status, input string msg);
      repeat (4) drive_word(1'b0, '0);
      check_value(vpid, exp_vpid, {msg, " vpid"});
      check_value({30'd0, status}, {30'd0, exp_status}, {msg, " status"});
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic reset_values();
      check_value(vpid, 32'd0, "reset vpid");
      check_value({30'd0, status}, 32'd0, "reset status");
   endtask

   task automatic good_packet();
      vpid_pkg::vpid_bytes_t bytes;
      bytes = random_bytes();
      build_packet(`VPID_DID_WORD, bytes, 1'b0, -1);
      send_packet(1'b0);
      expect_outputs(bytes, STATUS_GOOD, "good packet");
      good_bytes = bytes;
   endtask

   task automatic corrupted_checksum();
      build_packet(`VPID_DID_WORD, random_bytes(), 1'b1, -1);
      send_packet(1'b0);
      expect_outputs(good_bytes, STATUS_BAD, "corrupted checksum");
   endtask

   task automatic ignored_packets();
      build_packet(10'h180, random_bytes(), 1'b0, -1);
      send_packet(1'b0);
      expect_unchanged(good_bytes, STATUS_BAD, "other DID");
      build_packet(`VPID_DID_WORD, random_bytes(), 1'b0, 2);
      send_packet(1'b0);
      expect_unchanged(good_bytes, STATUS_BAD, "UDW parity fault");
   endtask

   task automatic gapped_packet();
      vpid_pkg::vpid_bytes_t bytes;
      bytes = random_bytes();
      build_packet(`VPID_DID_WORD, bytes, 1'b0, -1);
      send_packet(1'b1);
      expect_outputs(bytes, STATUS_GOOD, "gapped packet");
   endtask

   initial begin
      error_count   = 0;
      timeout_count = 0;
      lcg_state     = 32'd35563;
      good_bytes    = '0;
      calc_cs       = 1'b1;
      anc_in        = '0;
      repeat (8) @(posedge anc_detected);
      #1;
      calc_cs = 1'b0;

      reset_values();
      good_packet();
      corrupted_checksum();
      ignored_packets();
      gapped_packet();

      $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+logic
logic/vpid_pkg.sv
logic/anc_flag_detect.sv
logic/anc_checksum.sv
logic/vpid_packet_parser.sv
logic/vpid_receiver.sv
bench/vpid_receiver_sva.sv
bench/vpid_receiver_tb.sv

//--- logic/anc_checksum.sv
`timescale 1ns/1ps
`include "vpid_defines.svh"

module anc_checksum (
   input  logic                   anc_detected,
   input  logic                   calc_cs,
   input  logic [`ANC_WORD_W-1:0] word,
   input  logic                   cs_load,
   input  logic                   cs_add,
   output logic [`ANC_WORD_W-1:0] expected_cs
);

   // Running sum over bits 8..0 of each word
   logic [`ANC_CS_W-1:0] sum;
   logic [`ANC_CS_W-1:0] word_low;

   assign word_low = word[`ANC_CS_W-1:0];

   // ------------------------------
   // Accumulator
   // ------------------------------
   // The DID word starts a fresh sum, every later word adds to it
   always_ff @(posedge anc_detected or posedge calc_cs) begin
      if (calc_cs) begin
         sum <= '0;
      end else if (cs_load) begin
         sum <= word_low;
      end else if (cs_add) begin
         // Carry out of bit 8 is dropped, giving the sum modulo 512
         sum <= sum + word_low;
      end
   end

   // Checksum word carries the inverse of bit 8 in bit 9
   assign expected_cs = {~sum[`ANC_CS_W-1], sum};

endmodule

//--- logic/anc_flag_detect.sv
`timescale 1ns/1ps
`include "vpid_defines.svh"

module anc_flag_detect (
   input  logic                anc_detected,
   input  logic                calc_cs,
   input  vpid_pkg::anc_word_t anc_in,
   output logic                flag_seen
);

   // Number of flag words matched so far, 0 to 2
   logic [1:0] progress;
   logic       is_word0;
   logic       is_word1;

   assign is_word0 = (anc_in.data == `ADF_WORD0);
   assign is_word1 = (anc_in.data == `ADF_WORD1);

   // ------------------------------
   // Flag sequence tracking
   // ------------------------------
   // Only valid words move the count, so gaps in the strobe are transparent
   always_ff @(posedge anc_detected or posedge calc_cs) begin
      if (calc_cs) begin
         progress  <= 2'd0;
         flag_seen <= 1'b0;
      end else begin
         flag_seen <= 1'b0;
         if (anc_in.valid) begin
            if (progress == 2'd2 && is_word1) begin
               // Third flag word, pulse for one cycle and start over
               flag_seen <= 1'b1;
               progress  <= 2'd0;
            end else if (progress == 2'd1 && is_word1) begin
               progress <= 2'd2;
            end else if (is_word0) begin
               // A stray 000h may itself open a new flag
               progress <= 2'd1;
            end else begin
               progress <= 2'd0;
            end
         end
      end
   end

endmodule

//--- logic/vpid_defines.svh
`ifndef VPID_DEFINES_SVH
`define VPID_DEFINES_SVH

// Width of one ancillary data word on the stream
`define ANC_WORD_W 10

// Ancillary data flag is 000h followed by two words of 3FFh
`define ADF_WORD0 10'h000
`define ADF_WORD1 10'h3FF

// ------------------------------
// VPID header words, parity bits included
// ------------------------------
`define VPID_DID_WORD  10'h241
`define VPID_SDID_WORD 10'h101
`define VPID_DC_WORD   10'h104

// Number of user data words in a VPID packet
`define VPID_UDW_COUNT 4

// Checksum is the 9-bit sum of bits 8..0 of every word from DID to the last UDW
`define ANC_CS_W 9

`endif

//--- logic/vpid_packet_parser.sv
`timescale 1ns/1ps
`include "vpid_defines.svh"

module vpid_packet_parser (
   input  logic                   anc_detected,
   input  logic                   calc_cs,
   input  vpid_pkg::anc_word_t    anc_in,
   input  logic                   flag_seen,
   input  logic [`ANC_WORD_W-1:0] expected_cs,
   output logic                   cs_load,
   output logic                   cs_add,
   output logic [`ANC_WORD_W-1:0] cs_word,
   output vpid_pkg::vpid_bytes_t  vpid,
   output vpid_pkg::vpid_status_t status
);

   vpid_pkg::parse_state_t state;
   logic [1:0]             udw_cnt;
   vpid_pkg::vpid_bytes_t  staged;
   logic                   at_did;
   logic                   in_sum;

   // UDW parity: bit 8 is even parity of bits 7..0 and bit 9 is its inverse
   function automatic logic udw_parity_ok(input logic [`ANC_WORD_W-1:0] w);
      logic even;
      even = ^w[7:0];
      return (w[8] == even) && (w[9] == ~w[8]);
   endfunction

   // The word right after the flag may arrive while flag_seen is still high,
   // so that cycle is treated as the DID position too
   assign at_did = (state == vpid_pkg::DID) || (state == vpid_pkg::IDLE && flag_seen);
   assign in_sum = (state == vpid_pkg::SDID) || (state == vpid_pkg::DC) ||
                   (state == vpid_pkg::UDW);

   assign cs_word = anc_in.data;
   assign cs_load = anc_in.valid && at_did;
   assign cs_add  = anc_in.valid && in_sum;

   // ------------------------------
   // Packet FSM and outputs
   // ------------------------------
   always_ff @(posedge anc_detected or posedge calc_cs) begin
      if (calc_cs) begin
         state   <= vpid_pkg::IDLE;
         udw_cnt <= 2'd0;
         vpid    <= '0;
         status  <= '0;
      end else if (at_did) begin
         if (!anc_in.valid) begin
            state <= vpid_pkg::DID;
         end else if (anc_in.data == `VPID_DID_WORD) begin
            state <= vpid_pkg::SDID;
         end else begin
            // Some other ancillary packet, not ours
            state <= vpid_pkg::IDLE;
         end
      end else if (anc_in.valid) begin
         case (state)
            vpid_pkg::SDID: begin
               if (anc_in.data == `VPID_SDID_WORD) begin
                  state <= vpid_pkg::DC;
               end else begin
                  state <= vpid_pkg::IDLE;
               end
            end
            vpid_pkg::DC: begin
               udw_cnt <= 2'd0;
               if (anc_in.data == `VPID_DC_WORD) begin
                  state <= vpid_pkg::UDW;
               end else begin
                  state <= vpid_pkg::IDLE;
               end
            end
            vpid_pkg::UDW: begin
               udw_cnt <= udw_cnt + 2'd1;
               if (!udw_parity_ok(anc_in.data)) begin
                  // Drop the packet and leave the outputs alone
                  state <= vpid_pkg::IDLE;
               end else if (udw_cnt == 2'(`VPID_UDW_COUNT - 1)) begin
                  state <= vpid_pkg::CS;
               end
            end
            vpid_pkg::CS: begin
               state <= vpid_pkg::IDLE;
               if (anc_in.data == expected_cs) begin
                  vpid   <= staged;
                  status <= '{vpid_valid: 1'b1, checksum_error: 1'b0};
               end else begin
                  // Bytes keep the last good packet
                  status <= '{vpid_valid: 1'b0, checksum_error: 1'b1};
               end
            end
            default: begin
               state <= vpid_pkg::IDLE;
            end
         endcase
      end
   end

   // ------------------------------
   // UDW staging
   // ------------------------------
   // Bytes shift in from the bottom, so the first UDW ends up in byte1
   always_ff @(posedge anc_detected) begin
      if (anc_in.valid && state == vpid_pkg::UDW) begin
         staged <= {staged[23:0], anc_in.data[7:0]};
      end
   end

endmodule

//--- logic/vpid_pkg.sv
`include "vpid_defines.svh"

package vpid_pkg;

   // One strobed word of the ancillary stream
   typedef struct packed {
      logic                   valid;
      logic [`ANC_WORD_W-1:0] data;
   } anc_word_t;

   // The four payload bytes, byte1 first on the wire
   typedef struct packed {
      logic [7:0] byte1;
      logic [7:0] byte2;
      logic [7:0] byte3;
      logic [7:0] byte4;
   } vpid_bytes_t;

   // Status levels, both held until the next complete packet
   typedef struct packed {
      logic vpid_valid;
      logic checksum_error;
   } vpid_status_t;

   // Parser position inside a packet
   typedef enum logic [2:0] {IDLE, DID, SDID, DC, UDW, CS} parse_state_t;

endpackage

//--- logic/vpid_receiver.sv
`timescale 1ns/1ps
`include "vpid_defines.svh"

module vpid_receiver (
   input  logic                   anc_detected,
   input  logic                   calc_cs,
   input  vpid_pkg::anc_word_t    anc_in,
   output vpid_pkg::vpid_bytes_t  vpid,
   output vpid_pkg::vpid_status_t status
);

   logic                   flag_seen;
   logic                   cs_load;
   logic                   cs_add;
   logic [`ANC_WORD_W-1:0] cs_word;
   logic [`ANC_WORD_W-1:0] expected_cs;

   // Finds 000h 3FFh 3FFh ahead of each packet
   anc_flag_detect u_flag_detect (
      .anc_detected (anc_detected),
      .calc_cs      (calc_cs),
      .anc_in       (anc_in),
      .flag_seen    (flag_seen)
   );

   vpid_packet_parser u_parser (
      .anc_detected (anc_detected),
      .calc_cs      (calc_cs),
      .anc_in       (anc_in),
      .flag_seen    (flag_seen),
      .expected_cs  (expected_cs),
      .cs_load      (cs_load),
      .cs_add       (cs_add),
      .cs_word      (cs_word),
      .vpid         (vpid),
      .status       (status)
   );

   anc_checksum u_checksum (
      .anc_detected (anc_detected),
      .calc_cs      (calc_cs),
      .word         (cs_word),
      .cs_load      (cs_load),
      .cs_add       (cs_add),
      .expected_cs  (expected_cs)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f filelist.f --top-module vpid_receiver_tb -Mdir obj_dir

# The simulation output is shown and also searched for the pass line
if ./obj_dir/Vvpid_receiver_tb | tee /dev/stderr | grep -x "Test completed successfully" > /dev/null; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
